// File: rtl/memory_bus_pkg.sv
package memory_bus_pkg;

    typedef struct packed {
        logic [28:0] line;
        logic [2:0]  offset;
    } line_fields_type;

    // One byte address, read whole or split into line and offset.
    typedef union packed {
        logic [31:0]     raw;
        line_fields_type fields;
    } line_addr_type;

    typedef struct packed {
        logic          valid;
        logic          fence;
        line_addr_type address;
        logic [63:0]   wdata;
        logic [7:0]    wstrb;     // Zero strobe is a load.
    } core_req_type;

    typedef struct packed {
        logic        ready;
        logic [63:0] rdata;
    } core_rsp_type;

    typedef struct packed {
        logic        valid;
        logic        store;
        logic [31:0] address;     // Always 8-byte aligned.
        logic [63:0] wdata;
    } mem_req_type;

    typedef struct packed {
        logic        ready;
        logic [63:0] rdata;
    } mem_rsp_type;

endpackage

// File: rtl/store_buffer_pkg.sv
package store_buffer_pkg;

    localparam int max_index_width = 8;

    typedef struct packed {
        logic        valid;
        logic        dirty;
        logic [28:0] tag;         // Line number.
        logic [63:0] data;
    } entry_type;

    typedef struct packed {
        logic                       enable;
        logic [max_index_width-1:0] index;
        entry_type                  entry;
    } array_write_type;

    // Only the low index bits are decoded by the array.
    typedef struct packed {
        logic [max_index_width-1:0] index;
    } array_read_type;

endpackage

// File: rtl/store_buffer_array.sv
`timescale 1ns/1ps

module store_buffer_array
    import store_buffer_pkg::*;
#(
    parameter int entries = 16
) (
    input  logic            clock,
    input  array_read_type  read0,
    input  array_read_type  read1,
    input  array_write_type write0,
    input  array_write_type write1,
    output entry_type       entry0,
    output entry_type       entry1
);

    localparam int index_width = $clog2(entries);

    entry_type storage [entries] = '{default: '0};

    function automatic entry_type forward(
        array_read_type  port,
        entry_type       stored,
        array_write_type first,
        array_write_type second
    );
        logic [index_width-1:0] index;
        index = port.index[index_width-1:0];
        if (first.enable && first.index[index_width-1:0] == index) begin
            return first.entry;
        end
        if (second.enable && second.index[index_width-1:0] == index) begin
            return second.entry;
        end
        return stored;
    endfunction

    always_ff @(posedge clock) begin
        if (write1.enable) begin
            storage[write1.index[index_width-1:0]] <= write1.entry;
        end
        if (write0.enable) begin    // Port 0 wins on the same index.
            storage[write0.index[index_width-1:0]] <= write0.entry;
        end
    end

    assign entry0 = forward(read0, storage[read0.index[index_width-1:0]], write0, write1);
    assign entry1 = forward(read1, storage[read1.index[index_width-1:0]], write0, write1);

endmodule

// File: rtl/store_buffer_ctrl.sv
`timescale 1ns/1ps

module store_buffer_ctrl
    import memory_bus_pkg::*;
    import store_buffer_pkg::*;
#(
    parameter int entries = 16
) (
    input  logic            clock,
    input  logic            reset,
    input  core_req_type    core0_req,
    input  core_req_type    core1_req,
    output core_rsp_type    core0_rsp,
    output core_rsp_type    core1_rsp,
    output mem_req_type     mem0_req,
    output mem_req_type     mem1_req,
    input  mem_rsp_type     mem0_rsp,
    input  mem_rsp_type     mem1_rsp,
    output array_read_type  read0,
    output array_read_type  read1,
    output array_write_type write0,
    output array_write_type write1,
    input  entry_type       entry0,
    input  entry_type       entry1
);

    localparam int index_width = $clog2(entries);
    localparam logic [index_width-1:0] last_index = index_width'(entries - 1);

    typedef enum logic [1:0] {
        front_idle,
        front_miss,     // Waiting for the refill.
        front_scan,     // Fence walk.
        front_flush     // Fence waiting for a write-back.
    } front_state_type;

    typedef struct packed {
        front_state_type        state;
        logic [index_width-1:0] index;
        logic [63:0]            wdata;
        logic [7:0]             wstrb;
        logic                   ready;
        logic [63:0]            rdata;
    } front_type;

    typedef struct packed {
        mem_req_type req;
        logic        refill;    // Load still to follow the store.
        logic [31:0] refill_address;
    } back_type;

    typedef struct packed {
        logic        valid;
        logic        writeback;
        logic        refill;
        logic [31:0] writeback_address;
        logic [63:0] writeback_data;
        logic [31:0] refill_address;
    } handoff_type;

    function automatic logic [63:0] merge(
        logic [63:0] data,
        logic [63:0] wdata,
        logic [7:0]  wstrb
    );
        logic [63:0] result;
        result = data;
        for (int i = 0; i < 8; i++) begin
            if (wstrb[i]) begin
                result[8*i +: 8] = wdata[8*i +: 8];
            end
        end
        return result;
    endfunction

    for (genvar p = 0; p < 2; p++) begin : port_g
        core_req_type    req;
        mem_rsp_type     mem_rsp;
        entry_type       entry;
        core_rsp_type    core_rsp;
        mem_req_type     mem_req;
        array_read_type  read;
        array_write_type write;
        front_type       r_f;
        front_type       v_f;
        back_type        r_b;
        back_type        v_b;
        handoff_type     handoff;
        logic            ret;
        entry_type       ret_entry;
        logic            hit;
        logic            store;
        logic            advance;

        assign req     = (p == 0) ? core0_req : core1_req;
        assign mem_rsp = (p == 0) ? mem0_rsp : mem1_rsp;
        assign entry   = (p == 0) ? entry0 : entry1;

        // Back stage answer in the memory ready cycle.
        always_comb begin
            ret       = 1'b0;
            ret_entry = '{
                valid: 1'b1,
                dirty: 1'b0,
                tag:   r_b.req.address[31:3],
                data:  mem_rsp.rdata
            };
            if (r_b.req.valid && mem_rsp.ready) begin
                ret = !r_b.req.store || !r_b.refill;
            end
        end

        always_comb begin
            v_f        = r_f;
            v_f.ready  = 1'b0;
            v_f.rdata  = '0;
            handoff    = '0;
            write      = '0;
            advance    = 1'b0;
            hit        = entry.valid && entry.tag == req.address.fields.line;
            store      = |req.wstrb;
            read.index = max_index_width'(r_f.index);

            case (r_f.state)
                front_idle: begin
                    read.index = max_index_width'(req.address.fields.line[index_width-1:0]);
                    if (req.valid && req.fence) begin
                        v_f.state = front_scan;
                        v_f.index = '0;
                    end else if (req.valid) begin
                        v_f.index = req.address.fields.line[index_width-1:0];
                        v_f.wdata = req.wdata;
                        v_f.wstrb = req.wstrb;
                        if (hit) begin
                            write.enable      = store;
                            write.index       = read.index;
                            write.entry       = entry;
                            write.entry.dirty = 1'b1;
                            write.entry.data  = merge(entry.data, req.wdata, req.wstrb);
                            v_f.ready         = 1'b1;
                            v_f.rdata         = store ? '0 : entry.data;
                        end else begin
                            handoff.valid             = 1'b1;
                            handoff.writeback         = entry.valid && entry.dirty;
                            handoff.refill            = 1'b1;
                            handoff.writeback_address = {entry.tag, 3'b000};
                            handoff.writeback_data    = entry.data;
                            handoff.refill_address    = req.address.raw & ~32'h7;
                            v_f.state                 = front_miss;
                        end
                    end
                end
                front_miss: begin
                    if (ret) begin      // Refilled line takes the pending bytes.
                        write.enable      = 1'b1;
                        write.index       = read.index;
                        write.entry       = ret_entry;
                        write.entry.dirty = |r_f.wstrb;
                        write.entry.data  = merge(ret_entry.data, r_f.wdata, r_f.wstrb);
                        v_f.ready         = 1'b1;
                        v_f.rdata         = (|r_f.wstrb) ? '0 : ret_entry.data;
                        v_f.state         = front_idle;
                    end
                end
                front_scan: begin
                    if (entry.valid && entry.dirty) begin
                        handoff.valid             = 1'b1;
                        handoff.writeback         = 1'b1;
                        handoff.writeback_address = {entry.tag, 3'b000};
                        handoff.writeback_data    = entry.data;
                        v_f.state                 = front_flush;
                    end else begin
                        advance = 1'b1;
                    end
                end
                front_flush: begin
                    if (ret) begin      // Line is clean once memory has it.
                        write.enable      = 1'b1;
                        write.index       = read.index;
                        write.entry       = entry;
                        write.entry.dirty = 1'b0;
                        advance           = 1'b1;
                    end
                end
            endcase

            if (advance) begin
                if (r_f.index == last_index) begin
                    v_f.ready = 1'b1;
                    v_f.state = front_idle;
                end else begin
                    v_f.index = r_f.index + 1'b1;
                    v_f.state = front_scan;
                end
            end
        end

        always_comb begin
            v_b = r_b;
            if (r_b.req.valid && mem_rsp.ready) begin
                v_b.req.valid = 1'b0;
            end else if (!r_b.req.valid && r_b.refill) begin
                v_b.req    = '{valid: 1'b1, store: 1'b0, address: r_b.refill_address, wdata: '0};
                v_b.refill = 1'b0;
            end

            if (handoff.valid) begin
                v_b.refill         = handoff.refill && handoff.writeback;
                v_b.refill_address = handoff.refill_address;
                if (handoff.writeback) begin
                    v_b.req = '{
                        valid:   1'b1,
                        store:   1'b1,
                        address: handoff.writeback_address,
                        wdata:   handoff.writeback_data
                    };
                end else begin
                    v_b.req = '{
                        valid:   1'b1,
                        store:   1'b0,
                        address: handoff.refill_address,
                        wdata:   '0
                    };
                end
            end
        end

        assign core_rsp = '{ready: r_f.ready, rdata: r_f.rdata};
        assign mem_req  = r_b.req;

        always_ff @(posedge clock) begin
            if (!reset) begin
                r_f <= '0;
                r_b <= '0;
            end else begin
                r_f <= v_f;
                r_b <= v_b;
            end
        end
    end

    assign core0_rsp = port_g[0].core_rsp;
    assign core1_rsp = port_g[1].core_rsp;
    assign mem0_req  = port_g[0].mem_req;
    assign mem1_req  = port_g[1].mem_req;
    assign read0     = port_g[0].read;
    assign read1     = port_g[1].read;
    assign write0    = port_g[0].write;
    assign write1    = port_g[1].write;

endmodule

// File: rtl/store_buffer_top.sv
`timescale 1ns/1ps

module store_buffer_top
    import memory_bus_pkg::*;
    import store_buffer_pkg::*;
#(
    parameter int entries = 16
) (
    input  logic         clock,
    input  logic         reset,
    input  core_req_type core0_req,
    input  core_req_type core1_req,
    output core_rsp_type core0_rsp,
    output core_rsp_type core1_rsp,
    output mem_req_type  mem0_req,
    output mem_req_type  mem1_req,
    input  mem_rsp_type  mem0_rsp,
    input  mem_rsp_type  mem1_rsp
);

    array_read_type  read0;
    array_read_type  read1;
    array_write_type write0;
    array_write_type write1;
    entry_type       entry0;
    entry_type       entry1;

    store_buffer_ctrl #(
        .entries(entries)
    ) ctrl_i (
        .clock(clock),
        .reset(reset),
        .core0_req(core0_req),
        .core1_req(core1_req),
        .core0_rsp(core0_rsp),
        .core1_rsp(core1_rsp),
        .mem0_req(mem0_req),
        .mem1_req(mem1_req),
        .mem0_rsp(mem0_rsp),
        .mem1_rsp(mem1_rsp),
        .read0(read0),
        .read1(read1),
        .write0(write0),
        .write1(write1),
        .entry0(entry0),
        .entry1(entry1)
    );

    store_buffer_array #(
        .entries(entries)
    ) array_i (
        .clock(clock),
        .read0(read0),
        .read1(read1),
        .write0(write0),
        .write1(write1),
        .entry0(entry0),
        .entry1(entry1)
    );

endmodule

// File: testbench/clock_gen.sv
`timescale 1ns/1ps

module clock_gen #(
    parameter int half_period  = 2,
    parameter int reset_cycles = 5
) (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever #(half_period) clock = ~clock;
    end

    initial begin
        reset = 1'b0;
        repeat (reset_cycles) @(posedge clock);
        @(negedge clock);
        reset = 1'b1;    // Released away from the active edge.
    end

endmodule

// File: testbench/data_memory.sv
`timescale 1ns/1ps

module data_memory
    import memory_bus_pkg::*;
#(
    parameter int latency = 3
) (
    input  logic        clock,
    input  logic        reset,
    input  mem_req_type req0,
    input  mem_req_type req1,
    output mem_rsp_type rsp0,
    output mem_rsp_type rsp1
);

    logic [63:0] words [logic [28:0]];    // Shared by both ports.
    mem_req_type req [2];
    mem_rsp_type rsp [2] = '{default: '0};
    logic        busy [2] = '{default: 1'b0};
    int          count [2] = '{default: 0};

    assign req[0] = req0;
    assign req[1] = req1;
    assign rsp0   = rsp[0];
    assign rsp1   = rsp[1];

    // Unwritten words read as a pattern of their own address.
    function automatic logic [63:0] fill_word(input logic [31:0] address);
        return {address ^ 32'h5a5a_c3c3, ~address};
    endfunction

    always @(posedge clock) begin
        for (int p = 0; p < 2; p++) begin
            rsp[p] <= '0;
            if (!reset) begin
                busy[p] <= 1'b0;
            end else if (busy[p] && count[p] != 0) begin
                count[p] <= count[p] - 1;
            end else if (busy[p]) begin
                busy[p]      <= 1'b0;
                rsp[p].ready <= 1'b1;
                if (req[p].store) begin
                    words[req[p].address[31:3]] = req[p].wdata;
                end else if (words.exists(req[p].address[31:3])) begin
                    rsp[p].rdata <= words[req[p].address[31:3]];
                end else begin
                    rsp[p].rdata <= fill_word({req[p].address[31:3], 3'b000});
                end
            end else if (req[p].valid && !rsp[p].ready) begin
                busy[p]  <= 1'b1;
                count[p] <= latency - 1;
            end
        end
    end

endmodule

// File: testbench/store_buffer_properties.sv
`timescale 1ns/1ps

module store_buffer_properties
    import memory_bus_pkg::*;
    import store_buffer_pkg::*;
(
    input logic            clock,
    input logic            reset,
    input core_rsp_type    core0_rsp,
    input core_rsp_type    core1_rsp,
    input mem_req_type     mem0_req,
    input mem_req_type     mem1_req,
    input mem_rsp_type     mem0_rsp,
    input mem_rsp_type     mem1_rsp,
    input array_write_type write0,
    input array_write_type write1
);

    assert property (@(posedge clock) !reset |=> !mem0_req.valid && !mem1_req.valid
            && !core0_rsp.ready && !core1_rsp.ready && !write0.enable && !write1.enable)
        else $error("Outputs or array writes active in the cycle after reset.");

    // A request waits unchanged for its ready.
    assert property (@(posedge clock) disable iff (!reset)
            mem0_req.valid && !mem0_rsp.ready |=> mem0_req.valid && $stable(mem0_req))
        else $error("Memory port 0 request dropped or changed before ready.");

    assert property (@(posedge clock) disable iff (!reset)
            mem1_req.valid && !mem1_rsp.ready |=> mem1_req.valid && $stable(mem1_req))
        else $error("Memory port 1 request dropped or changed before ready.");

    assert property (@(posedge clock) disable iff (!reset)
            (!mem0_req.valid || mem0_req.address[2:0] == 3'b000)
            && (!mem1_req.valid || mem1_req.address[2:0] == 3'b000))
        else $error("Memory request address is not 8-byte aligned.");

endmodule

// File: testbench/store_buffer_tb.sv
`timescale 1ns/1ps

module store_buffer_tb
    import memory_bus_pkg::*;
();

    localparam int entries         = 16;
    localparam int latency         = 3;
    localparam int line_count      = 64;
    localparam int random_ops      = 400;
    localparam int operation_count = random_ops + 26;
    localparam int fence_count     = 3;
    localparam int cycle_limit     = operation_count * (2 * (latency + 3) + 2)
                                   + fence_count * entries * (latency + 3) + 500;
    localparam logic [28:0] base_line = 29'h0000_2000;

    logic         clock;
    logic         reset;
    core_req_type core_req [2];
    core_rsp_type core_rsp [2];
    mem_req_type  mem_req [2];
    mem_rsp_type  mem_rsp [2];

    logic [7:0]   model_bytes [logic [31:0]];
    logic [63:0]  shadow [logic [28:0]];    // Memory as seen through store traffic.
    logic         pending = 1'b0;
    logic         pending_fence = 1'b0;
    int           pending_port = 0;
    logic [63:0]  pending_rdata = '0;
    int           seed = 74464;
    int           cycles = 0;

    clock_gen #(.half_period(2), .reset_cycles(5)) clock_i (.clock(clock), .reset(reset));

    store_buffer_top #(
        .entries(entries)
    ) dut_i (
        .clock(clock),
        .reset(reset),
        .core0_req(core_req[0]),
        .core1_req(core_req[1]),
        .core0_rsp(core_rsp[0]),
        .core1_rsp(core_rsp[1]),
        .mem0_req(mem_req[0]),
        .mem1_req(mem_req[1]),
        .mem0_rsp(mem_rsp[0]),
        .mem1_rsp(mem_rsp[1])
    );

    data_memory #(
        .latency(latency)
    ) memory_i (
        .clock(clock),
        .reset(reset),
        .req0(mem_req[0]),
        .req1(mem_req[1]),
        .rsp0(mem_rsp[0]),
        .rsp1(mem_rsp[1])
    );

    bind store_buffer_top store_buffer_properties properties_i (
        .clock(clock),
        .reset(reset),
        .core0_rsp(core0_rsp),
        .core1_rsp(core1_rsp),
        .mem0_req(mem0_req),
        .mem1_req(mem1_req),
        .mem0_rsp(mem0_rsp),
        .mem1_rsp(mem1_rsp),
        .write0(write0),
        .write1(write1)
    );

    function automatic logic [63:0] fill_word(input logic [31:0] address);
        return {address ^ 32'h5a5a_c3c3, ~address};
    endfunction

    function automatic logic [31:0] line_address(input int k, input logic [2:0] offset);
        return {base_line + 29'(k), offset};
    endfunction

    function automatic logic [63:0] model_word(input logic [28:0] line);
        logic [63:0] word;
        logic [31:0] address;
        word = fill_word({line, 3'b000});
        for (int i = 0; i < 8; i++) begin
            address = {line, 3'b000} + 32'(i);
            if (model_bytes.exists(address)) begin
                word[8*i +: 8] = model_bytes[address];
            end
        end
        return word;
    endfunction

    // Store bytes land in lanes by strobe, whatever the offset.
    function automatic logic [63:0] model_access(
        input logic [31:0] address,
        input logic [63:0] wdata,
        input logic [7:0]  wstrb
    );
        for (int i = 0; i < 8; i++) begin
            if (wstrb[i]) begin
                model_bytes[{address[31:3], 3'b000} + 32'(i)] = wdata[8*i +: 8];
            end
        end
        return (wstrb != 8'h00) ? 64'h0 : model_word(address[31:3]);
    endfunction

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    task automatic check(
        input string       name,
        input logic [63:0] actual,
        input logic [63:0] expected
    );
        if (actual !== expected) begin
            fail_run($sformatf("MISMATCH %s: actual %h, expected %h", name, actual, expected));
        end
    endtask

    // Called on a falling edge, returns on the falling edge after ready.
    task automatic send(
        input int          port,
        input logic        fence,
        input logic [31:0] address,
        input logic [63:0] wdata,
        input logic [7:0]  wstrb
    );
        core_req_type request;
        request             = '0;
        request.valid       = 1'b1;
        request.fence       = fence;
        request.address.raw = address;
        request.wdata       = wdata;
        request.wstrb       = fence ? 8'h00 : wstrb;
        pending_rdata       = fence ? 64'h0 : model_access(address, wdata, wstrb);
        pending_port        = port;
        pending_fence       = fence;
        pending             = 1'b1;
        core_req[port] = request;
        @(negedge clock);
        core_req[port] = '0;
        while (pending) begin
            @(negedge clock);
        end
    endtask

    task automatic check_memory();
        logic [28:0] line;
        logic [63:0] stored;
        for (int k = 0; k < line_count; k++) begin
            line   = base_line + 29'(k);
            stored = shadow.exists(line) ? shadow[line] : fill_word({line, 3'b000});
            check($sformatf("memory[%h]", {line, 3'b000}), stored, model_word(line));
        end
    endtask

    always @(posedge clock) begin
        cycles++;
        if (reset) begin
            for (int p = 0; p < 2; p++) begin
                if (mem_req[p].valid && mem_rsp[p].ready && mem_req[p].store) begin
                    shadow[mem_req[p].address[31:3]] = mem_req[p].wdata;
                end
                if (!core_rsp[p].ready) begin
                    check($sformatf("core%0d_rsp.rdata", p), core_rsp[p].rdata, 64'h0);
                end else if (!pending || pending_port != p) begin
                    fail_run($sformatf("Port %0d gave a ready with no request pending.", p));
                end else begin
                    check($sformatf("core%0d_rsp.rdata", p), core_rsp[p].rdata, pending_rdata);
                    pending = 1'b0;
                end
            end
        end
        if (cycles >= cycle_limit) begin
            if (pending && pending_fence) begin
                fail_run($sformatf("Fence on port %0d never answered.", pending_port));
            end else if (pending) begin
                fail_run($sformatf("Request on port %0d never got a ready.", pending_port));
            end else begin
                fail_run("The run went past its cycle limit.");
            end
        end
    end

    initial begin
        int          k;
        logic [2:0]  offset;
        logic [63:0] data;
        logic [7:0]  strobe;
        core_req[0] = '0;
        core_req[1] = '0;
        wait (reset === 1'b1);
        repeat (2) @(negedge clock);

        // Stores from both ports merge into one line, then hits read it back.
        send(0, 1'b0, line_address(5, 3'd0), 64'h0, 8'h00);
        send(1, 1'b0, line_address(5, 3'd2), 64'h1111_2222_3333_4444, 8'h0f);
        send(0, 1'b0, line_address(5, 3'd4), 64'haaaa_bbbb_cccc_dddd, 8'hc0);
        send(1, 1'b0, line_address(5, 3'd0), 64'h0, 8'h00);
        send(0, 1'b0, line_address(5, 3'd1), 64'h0123_4567_89ab_cdef, 8'h5a);
        send(0, 1'b0, line_address(5, 3'd0), 64'h0, 8'h00);
        send(1, 1'b0, line_address(5, 3'd7), 64'h0, 8'h00);

        send(0, 1'b0, line_address(40, 3'd0), 64'h0, 8'h00);
        send(1, 1'b0, line_address(41, 3'd3), 64'hffff_ffff_ffff_ffff, 8'h00);

        // Lines 3, 19 and 35 share one entry.
        send(0, 1'b0, line_address(3, 3'd0), 64'h3333_0303_3333_0303, 8'hff);
        send(1, 1'b0, line_address(19, 3'd0), 64'h1919_9191_1919_9191, 8'h3c);
        send(0, 1'b0, line_address(35, 3'd0), 64'h3535_5353_3535_5353, 8'hff);
        send(1, 1'b0, line_address(3, 3'd0), 64'h0, 8'h00);
        send(0, 1'b0, line_address(19, 3'd0), 64'h0, 8'h00);
        send(1, 1'b0, line_address(35, 3'd0), 64'h0, 8'h00);

        send(0, 1'b0, line_address(7, 3'd0), 64'h0707_0707_7070_7070, 8'hff);
        send(1, 1'b0, line_address(8, 3'd0), 64'h0808_8080_0808_8080, 8'h0f);
        send(0, 1'b0, line_address(24, 3'd0), 64'h2424_4242_2424_4242, 8'hf0);
        send(0, 1'b1, 32'h0, 64'h0, 8'h00);
        check_memory();
        send(1, 1'b0, line_address(9, 3'd0), 64'h0909_9090_0909_9090, 8'h81);
        send(0, 1'b0, line_address(25, 3'd0), 64'h2525_5252_2525_5252, 8'h7e);
        send(1, 1'b1, 32'h0, 64'h0, 8'h00);
        check_memory();
        send(0, 1'b0, line_address(7, 3'd0), 64'h0, 8'h00);
        send(1, 1'b0, line_address(24, 3'd0), 64'h0, 8'h00);
        send(0, 1'b0, line_address(25, 3'd0), 64'h0, 8'h00);

        for (int i = 0; i < random_ops; i++) begin
            k      = $random(seed) & (line_count - 1);
            offset = 3'($random(seed));
            data   = {$random(seed), $random(seed)};
            strobe = ($random(seed) & 1) ? 8'($random(seed)) : 8'h00;
            send(i % 2, 1'b0, line_address(k, offset), data, strobe);
        end
        send(0, 1'b1, 32'h0, 64'h0, 8'h00);
        check_memory();

        $display("Test passed");
        $finish;
    end

endmodule

// File: sources.f
rtl/memory_bus_pkg.sv
rtl/store_buffer_pkg.sv
rtl/store_buffer_array.sv
rtl/store_buffer_ctrl.sv
rtl/store_buffer_top.sv
testbench/clock_gen.sv
testbench/data_memory.sv
testbench/store_buffer_properties.sv
testbench/store_buffer_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module store_buffer_tb \
    -f sources.f -o store_buffer_sim

output="$(./obj_dir/store_buffer_sim 2>&1 | tee /dev/stderr)"

if grep -qx "Test passed" <<< "$output"; then
    exit 0
fi
echo "Simulation did not report a pass." >&2
exit 1
